//--- hdl/mold_pkg.sv
////////////////////////////////////////////////////////////
// moldudp64 parser shared definitions
// protocol field widths, stream lane types, parser states
////////////////////////////////////////////////////////////
package mold_pkg;

	// stream geometry
	localparam int AXI_DATA_W = 64;
	localparam int AXI_KEEP_W = AXI_DATA_W / 8;
	// byte count 0 to 8 needs one more bit than a lane index
	localparam int KEEP_LW = $clog2(AXI_KEEP_W) + 1;

	// moldudp64 header fields
	localparam int SID_W = 80;
	localparam int SEQ_NUM_W = 64;
	// message length and message count
	localparam int ML_W = 16;

	typedef logic [AXI_DATA_W-1:0] axis_data_t;
	typedef logic [AXI_KEEP_W-1:0] axis_keep_t;
	typedef logic [KEEP_LW-1:0] lane_cnt_t;
	typedef logic [SID_W-1:0] sid_t;
	typedef logic [SEQ_NUM_W-1:0] seq_num_t;
	typedef logic [ML_W-1:0] mold_len_t;

	// state describes the beat currently held in the input register
	typedef enum logic [2:0] {
		IDLE,
		HDR0,
		HDR1,
		// last header beat, also holds the first length field
		HDR2_MSG,
		MSG,
		// length field split over lane 7 and lane 0 of the next beat
		LEN_SPLIT,
		// length field at lanes 0 and 1 of this beat
		LEN_ALIGN
	} mold_state_e;

endpackage

//--- hdl/mold_frame_ctrl.sv
////////////////////////////////////////////////////////////
// moldudp64 framing control
// input register, parser FSM, message count and
// remaining length countdown, output mask
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mold_frame_ctrl (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  tvalid_i,
	input  mold_pkg::axis_keep_t  tkeep_i,
	input  mold_pkg::axis_data_t  tdata_i,
	input  mold_pkg::mold_len_t   next_len_i,
	input  logic                  next_len_v_i,
	output logic                  beat_v_o,
	output mold_pkg::axis_data_t  beat_data_o,
	output mold_pkg::axis_keep_t  beat_keep_o,
	output mold_pkg::mold_state_e state_o,
	output mold_pkg::lane_cnt_t   shift_o,
	output logic                  msg_v_o,
	output logic                  msg_end_o,
	output logic                  msg_start_o,
	output mold_pkg::axis_keep_t  msg_mask_o
);

	logic                  beat_v_q;
	mold_pkg::axis_data_t  beat_data_q;
	mold_pkg::axis_keep_t  beat_keep_q;

	mold_pkg::mold_state_e state_q, state_d;
	// lane where message data starts in each beat, 8 means next beat
	mold_pkg::lane_cnt_t   shift_q, shift_d;
	mold_pkg::mold_len_t   cnt_q, cnt_d;
	mold_pkg::mold_len_t   rem_q, rem_d;
	logic                  first_q, first_d;
	// length of the new message is still sitting in the carry bytes
	logic                  pend_q, pend_d;

	mold_pkg::mold_len_t   cur_len;
	mold_pkg::mold_len_t   cnt_hdr;
	logic [mold_pkg::KEEP_LW:0] end_pos;
	logic                  msg_v;
	logic                  msg_end;
	logic                  cnt_load;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			beat_v_q <= 1'b0;
		end else begin
			beat_v_q <= tvalid_i;
		end
		beat_data_q <= tdata_i;
		beat_keep_q <= tkeep_i;
	end

	assign cur_len = pend_q ? next_len_i : rem_q;
	assign cnt_hdr = {beat_data_q[23:16], beat_data_q[31:24]};
	assign msg_v = beat_v_q && (state_q == mold_pkg::MSG);
	assign msg_end = msg_v && (cur_len <= mold_pkg::mold_len_t'(8));
	assign cnt_load = state_q == mold_pkg::HDR2_MSG;

	// lane after the last byte, plus 8, once the message ends in this beat
	assign end_pos = cur_len[mold_pkg::KEEP_LW-1:0] + shift_q;

	always_comb begin
		state_d = state_q;
		shift_d = shift_q;
		cnt_d = cnt_q;
		rem_d = rem_q;
		first_d = 1'b0;
		pend_d = 1'b0;
		case (state_q)
			mold_pkg::IDLE: begin
				if (tvalid_i) begin
					state_d = mold_pkg::HDR0;
				end
			end
			mold_pkg::HDR0: state_d = mold_pkg::HDR1;
			mold_pkg::HDR1: state_d = mold_pkg::HDR2_MSG;
			mold_pkg::HDR2_MSG: begin
				state_d = mold_pkg::MSG;
				cnt_d = cnt_hdr;
				shift_d = mold_pkg::lane_cnt_t'(6);
				first_d = 1'b1;
				if (next_len_v_i) begin
					rem_d = next_len_i;
				end
			end
			mold_pkg::LEN_SPLIT, mold_pkg::LEN_ALIGN: begin
				state_d = mold_pkg::MSG;
				shift_d = (state_q == mold_pkg::LEN_SPLIT) ? 4'd1 : 4'd2;
				first_d = 1'b1;
				if (next_len_v_i) begin
					rem_d = next_len_i;
				end
			end
			mold_pkg::MSG: begin
				if (msg_v) begin
					rem_d = cur_len - mold_pkg::mold_len_t'(8);
				end
				if (msg_end) begin
					cnt_d = cnt_q - mold_pkg::mold_len_t'(1);
					if (cnt_q == mold_pkg::mold_len_t'(1)) begin
						// a following packet may already be on the input
						state_d = tvalid_i ? mold_pkg::HDR0 : mold_pkg::IDLE;
					end else if (end_pos == 5'd15) begin
						state_d = mold_pkg::LEN_SPLIT;
					end else if (end_pos == 5'd16) begin
						state_d = mold_pkg::LEN_ALIGN;
					end else begin
						// next length and data start in this same beat
						shift_d = mold_pkg::lane_cnt_t'(end_pos - 5'd6);
						first_d = 1'b1;
						pend_d = 1'b1;
					end
				end
			end
			default: state_d = mold_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state_q <= mold_pkg::IDLE;
			shift_q <= '0;
			cnt_q <= '0;
			rem_q <= '0;
			first_q <= 1'b0;
			pend_q <= 1'b0;
		end else begin
			state_q <= state_d;
			shift_q <= shift_d;
			cnt_q <= cnt_d;
			rem_q <= rem_d;
			// hold flags while the stream pauses inside a message
			first_q <= (state_q == mold_pkg::MSG && !beat_v_q) ? first_q : first_d;
			pend_q <= (state_q == mold_pkg::MSG && !beat_v_q) ? pend_q : pend_d;
		end
	end

	assign beat_v_o = beat_v_q;
	assign beat_data_o = beat_data_q;
	assign beat_keep_o = beat_keep_q;
	assign state_o = state_q;
	assign shift_o = shift_q;
	assign msg_v_o = msg_v;
	assign msg_end_o = msg_end;
	assign msg_start_o = msg_v && first_q;
	assign msg_mask_o = (cur_len >= mold_pkg::mold_len_t'(8)) ? '1 :
		~(mold_pkg::axis_keep_t'('1) << cur_len[mold_pkg::KEEP_LW-2:0]);

	a_state_known : assert property (@(posedge clk) disable iff (!nreset)
		!$isunknown(state_q));

	// count comes from a valid third header beat only
	a_cnt_load_hdr2 : assert property (@(posedge clk) disable iff (!nreset)
		cnt_load |-> beat_v_q);

	// a message end with no count left means a header with a zero count
	a_end_within_count : assert property (@(posedge clk) disable iff (!nreset)
		msg_end_o |-> (cnt_q != '0));

endmodule

//--- hdl/mold_header.sv
////////////////////////////////////////////////////////////
// moldudp64 header capture
// session id and sequence number from the header beats,
// sequence number advances on every finished message
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mold_header (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  beat_v_i,
	input  mold_pkg::axis_data_t  beat_data_i,
	input  mold_pkg::mold_state_e state_i,
	input  logic                  msg_end_i,
	output mold_pkg::sid_t        sid_o,
	output mold_pkg::seq_num_t    seq_num_o
);

	mold_pkg::sid_t     sid_q;
	mold_pkg::seq_num_t seq_q;

	logic sid_load_hi;
	logic sid_load_lo;
	logic seq_load_hi;
	logic seq_load_lo;
	logic seq_inc;

	// sid bytes 0..7 in beat 0, bytes 8..9 at lanes 0..1 of beat 1
	assign sid_load_hi = beat_v_i && (state_i == mold_pkg::HDR0);
	assign sid_load_lo = beat_v_i && (state_i == mold_pkg::HDR1);
	// seq bytes 0..5 at lanes 2..7 of beat 1, bytes 6..7 at lanes 0..1 of beat 2
	assign seq_load_hi = sid_load_lo;
	assign seq_load_lo = beat_v_i && (state_i == mold_pkg::HDR2_MSG);
	assign seq_inc = msg_end_i;

	// wire order is big endian, first byte lands in the msb
	always_ff @(posedge clk) begin
		if (sid_load_hi) begin
			for (int i = 0; i < 8; i++) begin
				sid_q[mold_pkg::SID_W-1-8*i -: 8] <= beat_data_i[8*i +: 8];
			end
		end
		if (sid_load_lo) begin
			sid_q[15:8] <= beat_data_i[7:0];
			sid_q[7:0] <= beat_data_i[15:8];
		end
	end

	always_ff @(posedge clk) begin
		if (seq_load_hi) begin
			for (int i = 2; i < 8; i++) begin
				seq_q[mold_pkg::SEQ_NUM_W-1-8*(i-2) -: 8] <= beat_data_i[8*i +: 8];
			end
		end
		if (seq_load_lo) begin
			seq_q[15:8] <= beat_data_i[7:0];
			seq_q[7:0] <= beat_data_i[15:8];
		end else if (seq_inc) begin
			// each message carries its own number
			seq_q <= seq_q + mold_pkg::seq_num_t'(1);
		end
	end

	assign sid_o = sid_q;
	assign seq_num_o = seq_q;

	// a message end during header capture would lose the loaded value
	a_seq_load_inc : assert property (@(posedge clk) disable iff (!nreset)
		(seq_load_hi || seq_load_lo) |-> !seq_inc);

endmodule

//--- hdl/mold_realign.sv
////////////////////////////////////////////////////////////
// moldudp64 payload realignment
// merges carried bytes with the next beat into lane 0
// aligned words and decodes message length fields
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mold_realign (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  beat_v_i,
	input  mold_pkg::axis_data_t  beat_data_i,
	input  mold_pkg::mold_state_e state_i,
	input  mold_pkg::lane_cnt_t   shift_i,
	input  logic                  msg_v_i,
	output mold_pkg::axis_data_t  data_o,
	output mold_pkg::mold_len_t   next_len_o,
	output logic                  next_len_v_o
);

	// lanes 1..7 of the previous beat, lane 0 is never message data
	logic [mold_pkg::AXI_DATA_W-9:0] carry_q;

	mold_pkg::axis_data_t prev_full;
	mold_pkg::axis_data_t prev_len_sh;
	mold_pkg::lane_cnt_t  len_lane;
	mold_pkg::lane_cnt_t  beat_lanes;

	always_ff @(posedge clk) begin
		if (beat_v_i) begin
			carry_q <= beat_data_i[mold_pkg::AXI_DATA_W-1:8];
		end
	end

	assign prev_full = {carry_q, 8'h00};

	// bytes from shift_i upward come from the previous beat, the rest
	// of the word is filled from lane 0 of this beat
	assign beat_lanes = mold_pkg::lane_cnt_t'(mold_pkg::AXI_KEEP_W) - shift_i;
	assign data_o = (prev_full >> {shift_i, 3'b000})
		| (beat_data_i << {beat_lanes, 3'b000});

	// a length that began in the previous beat sits just below the data
	assign len_lane = shift_i - mold_pkg::lane_cnt_t'(2);
	assign prev_len_sh = prev_full >> {len_lane, 3'b000};

	always_comb begin
		case (state_i)
			mold_pkg::HDR2_MSG: begin
				next_len_o = {beat_data_i[39:32], beat_data_i[47:40]};
			end
			mold_pkg::LEN_SPLIT: begin
				// first byte was lane 7 of the previous beat
				next_len_o = {carry_q[mold_pkg::AXI_DATA_W-9 -: 8], beat_data_i[7:0]};
			end
			mold_pkg::LEN_ALIGN: begin
				next_len_o = {beat_data_i[7:0], beat_data_i[15:8]};
			end
			mold_pkg::MSG: begin
				next_len_o = {prev_len_sh[7:0], prev_len_sh[15:8]};
			end
			default: next_len_o = '0;
		endcase
	end

	// inside a message a length is only usable when both bytes were carried
	assign next_len_v_o = beat_v_i && ((state_i == mold_pkg::HDR2_MSG)
		|| (state_i == mold_pkg::LEN_SPLIT)
		|| (state_i == mold_pkg::LEN_ALIGN)
		|| ((state_i == mold_pkg::MSG) && (shift_i >= mold_pkg::lane_cnt_t'(3))));

	// carry holds at most 7 bytes, so word lane 7 always comes from the beat
	a_carry_partial : assert property (@(posedge clk) disable iff (!nreset)
		msg_v_i |-> (shift_i != '0) && (shift_i <= mold_pkg::lane_cnt_t'(8)));

endmodule

//--- hdl/moldudp64.sv
////////////////////////////////////////////////////////////
// moldudp64 packet parser top level
// splits udp payload beats into lane 0 aligned messages
// tagged with session id and sequence number
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module moldudp64 (
	input  logic                   clk,
	input  logic                   nreset,

	// stream from the udp stack
	input  logic                   udp_axis_tvalid_i,
	input  mold_pkg::axis_keep_t   udp_axis_tkeep_i,
	input  mold_pkg::axis_data_t   udp_axis_tdata_i,
	output logic                   udp_axis_tready_o,

	// message output
	output logic                   mold_msg_v_o,
	output logic                   mold_msg_start_o,
	output mold_pkg::axis_keep_t   mold_msg_mask_o,
	output mold_pkg::axis_data_t   mold_msg_data_o,
	output mold_pkg::sid_t         mold_msg_sid_o,
	output mold_pkg::seq_num_t     mold_msg_seq_num_o
);

	// registered beat and parser position
	logic                  beat_v;
	mold_pkg::axis_data_t  beat_data;
	mold_pkg::mold_state_e state;
	mold_pkg::lane_cnt_t   shift;

	logic                  msg_v;
	logic                  msg_end;
	mold_pkg::mold_len_t   next_len;
	logic                  next_len_v;

	// no back-pressure, every beat is accepted
	assign udp_axis_tready_o = 1'b1;
	assign mold_msg_v_o = msg_v;

	mold_frame_ctrl m_frame_ctrl (
		.clk          (clk),
		.nreset       (nreset),
		.tvalid_i     (udp_axis_tvalid_i),
		.tkeep_i      (udp_axis_tkeep_i),
		.tdata_i      (udp_axis_tdata_i),
		.next_len_i   (next_len),
		.next_len_v_i (next_len_v),
		.beat_v_o     (beat_v),
		.beat_data_o  (beat_data),
		.beat_keep_o  (),
		.state_o      (state),
		.shift_o      (shift),
		.msg_v_o      (msg_v),
		.msg_end_o    (msg_end),
		.msg_start_o  (mold_msg_start_o),
		.msg_mask_o   (mold_msg_mask_o)
	);

	mold_header m_header (
		.clk         (clk),
		.nreset      (nreset),
		.beat_v_i    (beat_v),
		.beat_data_i (beat_data),
		.state_i     (state),
		.msg_end_i   (msg_end),
		.sid_o       (mold_msg_sid_o),
		.seq_num_o   (mold_msg_seq_num_o)
	);

	mold_realign m_realign (
		.clk          (clk),
		.nreset       (nreset),
		.beat_v_i     (beat_v),
		.beat_data_i  (beat_data),
		.state_i      (state),
		.shift_i      (shift),
		.msg_v_i      (msg_v),
		.data_o       (mold_msg_data_o),
		.next_len_o   (next_len),
		.next_len_v_o (next_len_v)
	);

endmodule

//--- verification/tb_mold_tasks.svh
////////////////////////////////////////////////////////////
// moldudp64 testbench helpers
// packet building, beat driving and output word compares
////////////////////////////////////////////////////////////

// message lengths of the next packet to build
int len_q[$];
logic [7:0] pkt_bytes_q[$];
mold_pkg::axis_data_t beat_data_q[$];
mold_pkg::axis_keep_t beat_keep_q[$];

// expected output, one entry per word
mold_pkg::axis_data_t exp_data_q[$];
mold_pkg::axis_keep_t exp_mask_q[$];
logic exp_start_q[$];
mold_pkg::seq_num_t exp_seq_q[$];
mold_pkg::sid_t exp_sid_q[$];

// 20 header bytes, then a 2 byte length in front of each message
function automatic int packet_beats(input int n_msgs, input int msg_bytes);
	return (20 + 2 * n_msgs + msg_bytes + 7) / 8;
endfunction

task automatic build_packet(input mold_pkg::sid_t sid, input mold_pkg::seq_num_t seq);
	mold_pkg::axis_data_t word;
	mold_pkg::axis_keep_t mask;
	mold_pkg::mold_len_t len;
	logic [7:0] b;
	int i;
	int m;
	pkt_bytes_q.delete();
	// header fields go out most significant byte first
	for (i = 0; i < mold_pkg::SID_W / 8; i++)
		pkt_bytes_q.push_back(sid[mold_pkg::SID_W-1-8*i -: 8]);
	for (i = 0; i < mold_pkg::SEQ_NUM_W / 8; i++)
		pkt_bytes_q.push_back(seq[mold_pkg::SEQ_NUM_W-1-8*i -: 8]);
	len = mold_pkg::mold_len_t'(len_q.size());
	pkt_bytes_q.push_back(len[15:8]);
	pkt_bytes_q.push_back(len[7:0]);
	for (m = 0; m < len_q.size(); m++) begin
		len = mold_pkg::mold_len_t'(len_q[m]);
		pkt_bytes_q.push_back(len[15:8]);
		pkt_bytes_q.push_back(len[7:0]);
		word = '0;
		mask = '0;
		for (i = 0; i < len; i++) begin
			b = 8'($urandom);
			pkt_bytes_q.push_back(b);
			// first message byte lands in lane 0 of its first word
			word[8*(i%8) +: 8] = b;
			mask[i%8] = 1'b1;
			if (i % 8 == 7 || i == len - 1) begin
				exp_data_q.push_back(word);
				exp_mask_q.push_back(mask);
				exp_start_q.push_back(i < 8);
				exp_seq_q.push_back(seq + mold_pkg::seq_num_t'(m));
				exp_sid_q.push_back(sid);
				word = '0;
				mask = '0;
			end
		end
	end
	// packet starts on a fresh beat, last keep is a thermometer
	for (i = 0; i < pkt_bytes_q.size(); i = i + 8) begin
		word = '0;
		mask = '0;
		for (m = 0; m < 8 && i + m < pkt_bytes_q.size(); m++) begin
			word[8*m +: 8] = pkt_bytes_q[i+m];
			mask[m] = 1'b1;
		end
		beat_data_q.push_back(word);
		beat_keep_q.push_back(mask);
	end
endtask

// all queued beats go out back to back
task automatic drive_beats();
	while (beat_data_q.size() > 0) begin
		@(negedge clk);
		// the stream is never back-pressured
		check_flag("udp_axis_tready_o", 1'b1, udp_axis_tready_o);
		udp_axis_tvalid_i = 1'b1;
		udp_axis_tdata_i = beat_data_q.pop_front();
		udp_axis_tkeep_i = beat_keep_q.pop_front();
	end
	@(negedge clk);
	udp_axis_tvalid_i = 1'b0;
	udp_axis_tdata_i = '0;
	udp_axis_tkeep_i = '0;
endtask

task automatic check_data(input string name, input mold_pkg::axis_data_t exp, got);
	if (got !== exp) begin
		$display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
		errors++;
	end
endtask

task automatic check_mask(input string name, input mold_pkg::axis_keep_t exp, got);
	if (got !== exp) begin
		$display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
		errors++;
	end
endtask

task automatic check_flag(input string name, input logic exp, got);
	if (got !== exp) begin
		$display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
		errors++;
	end
endtask

task automatic check_seq(input string name, input mold_pkg::seq_num_t exp, got);
	if (got !== exp) begin
		$display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
		errors++;
	end
endtask

task automatic check_sid(input string name, input mold_pkg::sid_t exp, got);
	if (got !== exp) begin
		$display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
		errors++;
	end
endtask

task automatic compare_words();
	mold_pkg::axis_keep_t mask;
	mold_pkg::axis_data_t lanes;
	int k;
	while (exp_data_q.size() > 0 && got_data_q.size() > 0) begin
		mask = exp_mask_q.pop_front();
		// bytes past the end of a message are don't care
		for (k = 0; k < mold_pkg::AXI_KEEP_W; k++)
			lanes[8*k +: 8] = {8{mask[k]}};
		check_data("mold_msg_data_o", exp_data_q.pop_front() & lanes,
			got_data_q.pop_front() & lanes);
		check_mask("mold_msg_mask_o", mask, got_mask_q.pop_front());
		check_flag("mold_msg_start_o", exp_start_q.pop_front(), got_start_q.pop_front());
		check_seq("mold_msg_seq_num_o", exp_seq_q.pop_front(), got_seq_q.pop_front());
		check_sid("mold_msg_sid_o", exp_sid_q.pop_front(), got_sid_q.pop_front());
	end
	if (exp_data_q.size() > 0) begin
		$display("Missing output: %0d expected message words never came out",
			exp_data_q.size());
		errors++;
	end
	if (got_data_q.size() > 0) begin
		$display("Extra output: %0d words came out beyond the expected messages",
			got_data_q.size());
		errors++;
	end
	exp_data_q.delete();
	exp_mask_q.delete();
	exp_start_q.delete();
	exp_seq_q.delete();
	exp_sid_q.delete();
	got_data_q.delete();
	got_mask_q.delete();
	got_start_q.delete();
	got_seq_q.delete();
	got_sid_q.delete();
endtask

//--- verification/tb_moldudp64.sv
////////////////////////////////////////////////////////////
// moldudp64 parser testbench
// directed packets checked word by word against the protocol
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_moldudp64;

	localparam int CLK_PERIOD = 100;
	// cycles allowed per driven beat
	localparam int BEAT_CYCLES = 200;

	logic                  clk;
	logic                  nreset;
	logic                  udp_axis_tvalid_i;
	mold_pkg::axis_keep_t  udp_axis_tkeep_i;
	mold_pkg::axis_data_t  udp_axis_tdata_i;
	logic                  udp_axis_tready_o;
	logic                  mold_msg_v_o;
	logic                  mold_msg_start_o;
	mold_pkg::axis_keep_t  mold_msg_mask_o;
	mold_pkg::axis_data_t  mold_msg_data_o;
	mold_pkg::sid_t        mold_msg_sid_o;
	mold_pkg::seq_num_t    mold_msg_seq_num_o;

	// words seen on the output
	mold_pkg::axis_data_t got_data_q[$];
	mold_pkg::axis_keep_t got_mask_q[$];
	logic got_start_q[$];
	mold_pkg::seq_num_t got_seq_q[$];
	mold_pkg::sid_t got_sid_q[$];

	int errors;
	int pass_count;
	int fail_count;

	`include "tb_mold_tasks.svh"

	moldudp64 uut (
		.clk                (clk),
		.nreset             (nreset),
		.udp_axis_tvalid_i  (udp_axis_tvalid_i),
		.udp_axis_tkeep_i   (udp_axis_tkeep_i),
		.udp_axis_tdata_i   (udp_axis_tdata_i),
		.udp_axis_tready_o  (udp_axis_tready_o),
		.mold_msg_v_o       (mold_msg_v_o),
		.mold_msg_start_o   (mold_msg_start_o),
		.mold_msg_mask_o    (mold_msg_mask_o),
		.mold_msg_data_o    (mold_msg_data_o),
		.mold_msg_sid_o     (mold_msg_sid_o),
		.mold_msg_seq_num_o (mold_msg_seq_num_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// output monitor
	always @(posedge clk) begin
		if (mold_msg_v_o === 1'b1) begin
			got_data_q.push_back(mold_msg_data_o);
			got_mask_q.push_back(mold_msg_mask_o);
			got_start_q.push_back(mold_msg_start_o);
			got_seq_q.push_back(mold_msg_seq_num_o);
			got_sid_q.push_back(mold_msg_sid_o);
		end
	end

	task automatic run_and_check(input string name);
		int start_errors;
		int n_words;
		int limit;
		int cycles;
		start_errors = errors;
		n_words = exp_data_q.size();
		limit = BEAT_CYCLES * beat_data_q.size();
		cycles = 0;
		drive_beats();
		while (got_data_q.size() < n_words && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		// quiet period, nothing may come out once the count is used up
		repeat (16) @(negedge clk);
		compare_words();
		if (errors == start_errors) begin
			pass_count++;
			$display("Test %s: pass", name);
		end else begin
			fail_count++;
			$display("Test %s: fail", name);
		end
	endtask

	task automatic test_single_msg();
		len_q.delete();
		len_q.push_back(5);
		build_packet(80'h0123_4567_89ab_cdef_0011, 64'h0000_0000_0000_1000);
		run_and_check("single_msg");
	endtask

	task automatic test_three_msgs();
		len_q.delete();
		len_q.push_back(13);
		len_q.push_back(8);
		len_q.push_back(20);
		build_packet(80'h5345_5353_494f_4e30_3031, 64'h0000_0001_ffff_fffe);
		run_and_check("three_msgs");
	endtask

	// second message ends in lane 6, next length straddles the beats
	task automatic test_len_split();
		len_q.delete();
		len_q.push_back(7);
		len_q.push_back(8);
		len_q.push_back(16);
		build_packet(80'ha5a5_0000_1111_2222_3333, 64'h0000_0000_0000_0042);
		run_and_check("len_split");
	endtask

	// second message ends in lane 7, next length sits at lane 0
	task automatic test_len_align();
		len_q.delete();
		len_q.push_back(8);
		len_q.push_back(8);
		len_q.push_back(7);
		build_packet(80'h0f0e_0d0c_0b0a_0908_0706, 64'h1234_5678_9abc_def0);
		run_and_check("len_align");
	endtask

	task automatic test_back_to_back();
		len_q.delete();
		len_q.push_back(5);
		build_packet(80'h1111_2222_3333_4444_5555, 64'h0000_0000_0000_0100);
		len_q.delete();
		len_q.push_back(13);
		len_q.push_back(6);
		build_packet(80'h6666_7777_8888_9999_aaaa, 64'h0000_0000_0000_0900);
		run_and_check("back_to_back");
	endtask

	initial begin : watchdog
		int total_beats;
		// beats of every packet that the tests drive
		total_beats = packet_beats(1, 5) + packet_beats(3, 41) + packet_beats(3, 31)
			+ packet_beats(3, 23) + packet_beats(1, 5) + packet_beats(2, 19);
		#(BEAT_CYCLES * total_beats * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles",
			BEAT_CYCLES * total_beats);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : main
		int seed;
		seed = 3948;
		void'($urandom(seed));
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		nreset = 1'b0;
		udp_axis_tvalid_i = 1'b0;
		udp_axis_tkeep_i = '0;
		udp_axis_tdata_i = '0;
		repeat (2) @(negedge clk);
		nreset = 1'b1;
		test_single_msg();
		test_three_msgs();
		test_len_split();
		test_len_align();
		test_back_to_back();
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+verification
hdl/mold_pkg.sv
hdl/mold_frame_ctrl.sv
hdl/mold_header.sv
hdl/mold_realign.sv
hdl/moldudp64.sv
verification/tb_moldudp64.sv
